// File: mapper_settings.svh
// Memory mapper settings

`ifndef MAPPER_SETTINGS_SVH
`define MAPPER_SETTINGS_SVH

// programmable address regions, one active bit each
`define MAPPER_REGIONS 8

// 8-bit mapper registers seen by the CPU and the MCU
// upper half holds the region control and base pairs
`define MAPPER_REGS 32

// register doubling as the sound mailbox toward the Z80
`define MAPPER_SND_IDX 3

`endif

// File: mapper_pkg.sv
// Memory mapper types

`include "mapper_settings.svh"

package mapper_pkg;

    // register index, wide enough for the whole register file
    typedef logic [$clog2(`MAPPER_REGS)-1:0] reg_idx_t;

    // one register write, from either the CPU or the MCU side
    typedef struct packed {
        logic       en;
        reg_idx_t   idx;
        logic [7:0] data;
    } reg_wr_t;

    // settings of one region, taken from its control and base registers
    // size 0..3 selects 64 kB, 128 kB, 512 kB, 2048 kB
    // dtack is the wait cycle code passed to the bus logic
    typedef struct packed {
        logic [7:0] base;
        logic [1:0] dtack;
        logic [1:0] size;
    } region_cfg_t;

    // all regions side by side, region 0 in the low bits
    typedef region_cfg_t [`MAPPER_REGIONS-1:0] region_cfg_array_t;

endpackage

// File: mapper_access.sv
// Mapper register access arbiter

module mapper_access import mapper_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // 68000 side
    input  logic [23:1] addr,
    input  logic [15:0] cpu_dout,
    input  logic [1:0]  cpu_dswn,
    input  logic        cpu_asn,
    // MCU side
    input  logic [15:0] mcu_addr,
    input  logic [7:0]  mcu_dout,
    input  logic        mcu_wr,
    // no region selected, CPU owns the registers
    input  logic        region_none,
    output reg_wr_t     wr
);

    // address strobe and lower data strobe both asserted
    logic cpu_strobe;
    // strobe level from the previous cycle
    logic cpu_strobe_q;
    // first cycle of a strobe assertion
    logic cpu_wr;

    // only the low byte lane reaches the registers
    assign cpu_strobe = ~cpu_asn & ~cpu_dswn[0];
    assign cpu_wr     = cpu_strobe & ~cpu_strobe_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_strobe_q <= 1'b0;
        end else begin
            cpu_strobe_q <= cpu_strobe;
        end
    end

    // CPU writes while it sees no region, the MCU writes otherwise
    always_comb begin
        if (region_none) begin
            wr.en   = cpu_wr;
            // word address, so register index starts at address bit 1
            wr.idx  = addr[5:1];
            wr.data = cpu_dout[7:0];
        end else begin
            wr.en   = mcu_wr;
            wr.idx  = mcu_addr[4:0];
            wr.data = mcu_dout;
        end
    end

endmodule

// File: mapper_regs.sv
// Mapper register file

`include "mapper_settings.svh"

module mapper_regs import mapper_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  reg_wr_t           wr,
    // Z80 reads the mailbox
    input  logic              sndmap_rd,
    // per region view of the upper registers
    output region_cfg_array_t cfg,
    // sound mailbox toward the Z80
    output logic [7:0]        sndmap_dout,
    output logic              sndmap_obf,
    // read back toward the MCU
    output logic [7:0]        mcu_din
);

    // region control and base pairs start halfway up the file
    localparam int CFG_BASE = `MAPPER_REGS / 2;

    logic [7:0] mmr [`MAPPER_REGS];
    // index of the most recent write, used for MCU read back
    reg_idx_t   rd_idx;
    // write hits the mailbox register
    logic       snd_wr;

    assign snd_wr = wr.en && (wr.idx == reg_idx_t'(`MAPPER_SND_IDX));

    // register file, all zero after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MAPPER_REGS; i++) begin
                mmr[i] <= 8'd0;
            end
        end else if (wr.en) begin
            mmr[wr.idx] <= wr.data;
        end
    end

    // MCU read port follows the last written index
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_idx <= '0;
        end else if (wr.en) begin
            rd_idx <= wr.idx;
        end
    end

    // output buffer full flag
    // a Z80 read in the same cycle as a write clears it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sndmap_obf <= 1'b0;
        end else if (sndmap_rd) begin
            sndmap_obf <= 1'b0;
        end else if (snd_wr) begin
            sndmap_obf <= 1'b1;
        end
    end

    // control at 16+2n, base at 17+2n
    // control bits 7:4 are not used by the decoder
    always_comb begin
        for (int n = 0; n < `MAPPER_REGIONS; n++) begin
            cfg[n].size  = mmr[CFG_BASE + 2*n][1:0];
            cfg[n].dtack = mmr[CFG_BASE + 2*n][3:2];
            cfg[n].base  = mmr[CFG_BASE + 2*n + 1];
        end
    end

    assign sndmap_dout = mmr[`MAPPER_SND_IDX];
    assign mcu_din     = mmr[rd_idx];

endmodule

// File: region_decoder.sv
// Region address decoder

`include "mapper_settings.svh"

module region_decoder import mapper_pkg::*; (
    input  logic [23:1]                addr,
    input  logic [2:0]                 cpu_fc,
    input  region_cfg_array_t          cfg,
    // one hot, or zero when nothing matches
    output logic [`MAPPER_REGIONS-1:0] active,
    // wait cycle code of the winning region
    output logic [1:0]                 dtack_cyc,
    output logic                       region_none
);

    // raw compare result per region, several may be set
    logic [`MAPPER_REGIONS-1:0] match;
    // function code 7 marks an interrupt acknowledge cycle
    logic                       iack;

    assign iack = &cpu_fc;

    // compare the top address bits, fewer bits for larger regions
    always_comb begin
        for (int i = 0; i < `MAPPER_REGIONS; i++) begin
            case (cfg[i].size)
                // 64 kB
                2'd0: match[i] = addr[23:16] == cfg[i].base;
                // 128 kB
                2'd1: match[i] = addr[23:17] == cfg[i].base[7:1];
                // 512 kB
                2'd2: match[i] = addr[23:19] == cfg[i].base[7:3];
                // 2048 kB
                default: match[i] = addr[23:21] == cfg[i].base[7:5];
            endcase
        end
    end

    // lowest numbered match wins
    always_comb begin : pick
        logic found;
        found     = 1'b0;
        active    = '0;
        dtack_cyc = 2'd0;
        for (int i = 0; i < `MAPPER_REGIONS; i++) begin
            if (match[i] && !found) begin
                found     = 1'b1;
                active[i] = 1'b1;
                dtack_cyc = cfg[i].dtack;
            end
        end
        // no memory region answers an interrupt acknowledge
        if (iack) begin
            active    = '0;
            dtack_cyc = 2'd0;
        end
    end

    assign region_none = active == '0;

endmodule

// File: vblank_irq.sv
// Vertical blank interrupt

module vblank_irq (
    input  logic       clk,
    input  logic       rst,
    input  logic       vint,
    input  logic       cpu_asn,
    input  logic [2:0] cpu_fc,
    // active low priority level toward the 68000
    output logic [2:0] cpu_ipln,
    // autovector request, low during acknowledge
    output logic       cpu_vpan
);

    // registered vint for edge detection
    logic vint_q;
    // pending request, active low
    logic irqn;
    // interrupt acknowledge cycle, active low
    logic inta_n;

    assign inta_n = ~(&cpu_fc & ~cpu_asn);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vint_q <= 1'b0;
        end else begin
            vint_q <= vint;
        end
    end

    // acknowledge beats a new edge in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irqn <= 1'b1;
        end else if (!inta_n) begin
            irqn <= 1'b1;
        end else if (vint && !vint_q) begin
            irqn <= 1'b0;
        end
    end

    // level 4 shows as 3 on the inverted lines
    assign cpu_ipln = {irqn, 2'b11};
    assign cpu_vpan = inta_n;

endmodule

// File: mapper_top.sv
// Memory mapper top level

`include "mapper_settings.svh"

module mapper_top import mapper_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       vint,
    // 68000 interface
    input  logic [23:1]                addr,
    input  logic [15:0]                cpu_dout,
    input  logic [1:0]                 cpu_dswn,
    input  logic                       cpu_asn,
    input  logic [2:0]                 cpu_fc,
    output logic [2:0]                 cpu_ipln,
    output logic                       cpu_vpan,
    output logic [1:0]                 dtack_cyc,
    output logic [`MAPPER_REGIONS-1:0] active,
    // Z80 interface
    input  logic                       sndmap_rd,
    output logic [7:0]                 sndmap_dout,
    output logic                       sndmap_obf,
    // MCU interface
    input  logic [15:0]                mcu_addr,
    input  logic [7:0]                 mcu_dout,
    input  logic                       mcu_wr,
    output logic [7:0]                 mcu_din
);

    // write request from the arbiter
    reg_wr_t           wr;
    // region settings from the register file
    region_cfg_array_t cfg;
    // decoder sees no region, hands registers to the CPU
    logic              region_none;

    mapper_access u_access (
        .clk         (clk),
        .rst         (rst),
        .addr        (addr),
        .cpu_dout    (cpu_dout),
        .cpu_dswn    (cpu_dswn),
        .cpu_asn     (cpu_asn),
        .mcu_addr    (mcu_addr),
        .mcu_dout    (mcu_dout),
        .mcu_wr      (mcu_wr),
        .region_none (region_none),
        .wr          (wr)
    );

    mapper_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .wr          (wr),
        .sndmap_rd   (sndmap_rd),
        .cfg         (cfg),
        .sndmap_dout (sndmap_dout),
        .sndmap_obf  (sndmap_obf),
        .mcu_din     (mcu_din)
    );

    region_decoder u_decoder (
        .addr        (addr),
        .cpu_fc      (cpu_fc),
        .cfg         (cfg),
        .active      (active),
        .dtack_cyc   (dtack_cyc),
        .region_none (region_none)
    );

    vblank_irq u_irq (
        .clk      (clk),
        .rst      (rst),
        .vint     (vint),
        .cpu_asn  (cpu_asn),
        .cpu_fc   (cpu_fc),
        .cpu_ipln (cpu_ipln),
        .cpu_vpan (cpu_vpan)
    );

endmodule

// File: mapper_checker.sv
// Mapper bus rule assertions

`include "mapper_settings.svh"

module mapper_checker (
    input logic                       clk,
    input logic                       rst,
    input logic                       cpu_asn,
    input logic [2:0]                 cpu_fc,
    input logic [2:0]                 cpu_ipln,
    input logic                       sndmap_rd,
    input logic                       sndmap_obf,
    input logic [`MAPPER_REGIONS-1:0] active
);

    timeunit 1ns;
    timeprecision 100ps;

    // at most one region answers a bus cycle
    onehot_select: assert property (@(posedge clk) disable iff (rst) $onehot0(active))
        else $error("active select %b is not one-hot", active);

    // acknowledge withdraws the level 4 request at the next edge
    ack_clears_irq: assert property (@(posedge clk) disable iff (rst)
        (!cpu_asn && (cpu_fc == 3'd7)) |=> (cpu_ipln == 3'd7))
        else $error("cpu_ipln still %0d after an acknowledge", cpu_ipln);

    // a Z80 read always empties the mailbox, even against a write
    read_clears_obf: assert property (@(posedge clk) disable iff (rst)
        sndmap_rd |=> !sndmap_obf)
        else $error("sndmap_obf still set after a Z80 read");

endmodule

// File: tb_mapper.sv
// Memory mapper testbench

module tb_mapper;

    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        rst;
    logic        vint;
    logic [23:1] addr;
    logic [15:0] cpu_dout;
    logic [1:0]  cpu_dswn;
    logic        cpu_asn;
    logic [2:0]  cpu_fc;
    logic [2:0]  cpu_ipln;
    logic        cpu_vpan;
    logic [1:0]  dtack_cyc;
    logic [7:0]  active;
    logic        sndmap_rd;
    logic [7:0]  sndmap_dout;
    logic        sndmap_obf;
    logic [15:0] mcu_addr;
    logic [7:0]  mcu_dout;
    logic        mcu_wr;
    logic [7:0]  mcu_din;

    // trace lines, opcode plus four hex fields
    string       ops[$];
    logic [23:0] op_a[$];
    logic [23:0] op_b[$];
    logic [23:0] op_c[$];
    logic [23:0] op_d[$];
    int          fd;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    // zero until the trace length is known
    int          limit = 0;

    mapper_top dut_i (.*);

    bind mapper_top mapper_checker checker_i (
        .clk        (clk),
        .rst        (rst),
        .cpu_asn    (cpu_asn),
        .cpu_fc     (cpu_fc),
        .cpu_ipln   (cpu_ipln),
        .sndmap_rd  (sndmap_rd),
        .sndmap_obf (sndmap_obf),
        .active     (active)
    );

    always #20 clk = ~clk;

    // run length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("cycle limit of %0d reached before the trace finished", limit);
            $display("tests failed");
            $finish;
        end
    end

    // inputs change 2 ns after the edge
    task next_cycle;
        @(posedge clk);
        #2;
    endtask

    // just before the coming edge, outputs are stable
    task settle;
        #34;
    endtask

    task mismatch(input string what, input logic [23:0] exp, input logic [23:0] got);
        errors++;
        $display("ERROR %0t: %s expected %0h got %0h", $time, what, exp, got);
    endtask

    // one strobe assertion on the low byte lane
    task cpu_write(input logic [23:0] a, input logic [23:0] data);
        addr     = a[23:1];
        cpu_dout = {8'h00, data[7:0]};
        cpu_asn  = 1'b0;
        cpu_dswn = 2'b10;
        next_cycle();
        cpu_asn  = 1'b1;
        cpu_dswn = 2'b11;
        next_cycle();
    endtask

    // address 0 keeps region 0 active, so the MCU owns the registers
    task mcu_write(input logic [23:0] idx, input logic [23:0] data);
        addr     = '0;
        mcu_addr = {8'h00, idx[7:0]};
        mcu_dout = data[7:0];
        mcu_wr   = 1'b1;
        next_cycle();
        mcu_wr   = 1'b0;
        // read back port now shows the register just written
        settle();
        checks++;
        if (mcu_din !== data[7:0]) mismatch("mcu_din", data, 24'(mcu_din));
        next_cycle();
    endtask

    task decode(input logic [23:0] a, input logic [23:0] fc,
                input logic [23:0] exp_act, input logic [23:0] exp_dt);
        addr   = a[23:1];
        cpu_fc = fc[2:0];
        settle();
        checks += 2;
        if (active !== exp_act[7:0]) mismatch("active", exp_act, 24'(active));
        if (dtack_cyc !== exp_dt[1:0]) mismatch("dtack_cyc", exp_dt, 24'(dtack_cyc));
        next_cycle();
        cpu_fc = 3'd0;
    endtask

    // check the mailbox, then read it once
    task sound_read(input logic [23:0] exp_byte, input logic [23:0] exp_flag);
        settle();
        checks += 2;
        if (sndmap_dout !== exp_byte[7:0]) mismatch("sndmap_dout", exp_byte, 24'(sndmap_dout));
        if (sndmap_obf !== exp_flag[0]) mismatch("sndmap_obf", exp_flag, 24'(sndmap_obf));
        next_cycle();
        sndmap_rd = 1'b1;
        next_cycle();
        sndmap_rd = 1'b0;
    endtask

    // vint rises and stays high through the acknowledge
    task vblank(input logic [23:0] exp_before, input logic [23:0] exp_after);
        vint = 1'b1;
        next_cycle();
        settle();
        checks++;
        if (cpu_ipln !== exp_before[2:0]) mismatch("cpu_ipln pending", exp_before, 24'(cpu_ipln));
        next_cycle();
        cpu_asn = 1'b0;
        cpu_fc  = 3'd7;
        settle();
        checks++;
        if (cpu_vpan !== 1'b0) mismatch("cpu_vpan", 24'd0, 24'(cpu_vpan));
        next_cycle();
        cpu_asn = 1'b1;
        cpu_fc  = 3'd0;
        settle();
        checks++;
        if (cpu_ipln !== exp_after[2:0]) mismatch("cpu_ipln acked", exp_after, 24'(cpu_ipln));
        // held level must not raise a second request
        repeat (2) next_cycle();
        settle();
        checks++;
        if (cpu_ipln !== exp_after[2:0]) mismatch("cpu_ipln held", exp_after, 24'(cpu_ipln));
        vint = 1'b0;
        next_cycle();
    endtask

    task read_trace;
        int          n;
        string       op;
        logic [23:0] a;
        logic [23:0] b;
        logic [23:0] c;
        logic [23:0] d;
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s %h %h %h %h\n", op, a, b, c, d);
            if (n == 5) begin
                ops.push_back(op);
                op_a.push_back(a);
                op_b.push_back(b);
                op_c.push_back(c);
                op_d.push_back(d);
            end else if (n > 0 || !$feof(fd)) begin
                errors++;
                $display("trace line %0d could not be parsed", ops.size() + 1);
                break;
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        vint      = 1'b0;
        addr      = '0;
        cpu_dout  = '0;
        cpu_dswn  = 2'b11;
        cpu_asn   = 1'b1;
        cpu_fc    = 3'd0;
        sndmap_rd = 1'b0;
        mcu_addr  = '0;
        mcu_dout  = '0;
        mcu_wr    = 1'b0;
        fd = $fopen("mapper_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open mapper_trace.txt, nothing to run");
            $display("tests failed");
            $finish;
        end else begin
            read_trace();
            $fclose(fd);
            limit = 8 * ops.size() + 50;
            repeat (3) @(posedge clk);
            #2;
            rst = 1'b0;
            settle();
            checks++;
            if (cpu_ipln !== 3'd7) mismatch("cpu_ipln after reset", 24'd7, 24'(cpu_ipln));
            next_cycle();
            foreach (ops[i]) begin
                if (ops[i] == "W") cpu_write(op_a[i], op_b[i]);
                else if (ops[i] == "M") mcu_write(op_a[i], op_b[i]);
                else if (ops[i] == "D") decode(op_a[i], op_b[i], op_c[i], op_d[i]);
                else if (ops[i] == "S") sound_read(op_a[i], op_b[i]);
                else if (ops[i] == "V") vblank(op_a[i], op_b[i]);
                else begin
                    errors++;
                    $display("unknown trace opcode %s on line %0d", ops[i], i + 1);
                end
            end
            $display("checks %0d, errors %0d", checks, errors);
            if (errors == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule

// File: mapper_trace.txt
D 001234 0 01 0
S 00 0 0 0
W 10002A 40 0 0
W 100028 09 0 0
W 100036 40 0 0
W 100034 07 0 0
D 412345 0 04 2
D 5A0000 0 20 1
D 1A0000 0 00 0
D 412345 7 00 0
D 001234 7 00 0
M 03 A5 0 0
S A5 1 0 0
S A5 0 0 0
W 100006 5C 0 0
S 5C 1 0 0
S 5C 0 0 0
M 03 11 0 0
M 03 22 0 0
S 22 1 0 0
V 3 7 0 0
V 3 7 0 0
D 400000 0 04 2
D 420000 0 20 1
D 600000 0 00 0

// File: verilog.f
+incdir+.
mapper_pkg.sv
mapper_access.sv
mapper_regs.sv
region_decoder.sv
vblank_irq.sv
mapper_top.sv
mapper_checker.sv
tb_mapper.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module tb_mapper -o sim_mapper \
    && ./obj_dir/sim_mapper | grep -q "all tests passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
